// File: elk_pkg.sv
// Memory map constants, ROM slot codes, data byte type and bus address union
package elk_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Address widths and memory depths
	////////////////////////////////////////////////////////////////////////////

	// Core side address, 32 pages of 16 KB
	localparam int ext_addr_w = 19;
	// Byte offset inside one page
	localparam int page_off_w = 14;
	// Flat word address into either memory
	localparam int rom_addr_w = 17;
	// Seven ROM slots, eight RAM banks
	localparam int rom_words = 114688;
	localparam int ram_words = 131072;

	typedef logic [7:0] data_t;

	// Same address word, seen as a ROM page or as a RAM bank
	typedef union packed {
		struct packed {
			logic                  ram_flag;
			logic [1:0]            quad;
			logic [1:0]            bank;
			logic [page_off_w-1:0] offset;
		} rom_v;
		struct packed {
			logic                                 ram_flag;
			logic [ext_addr_w-page_off_w-2:0]     bank_num;
			logic [page_off_w-1:0]                offset;
		} ram_v;
	} ext_addr_u;

	////////////////////////////////////////////////////////////////////////////
	// ROM image slots
	////////////////////////////////////////////////////////////////////////////

	typedef logic [2:0] rom_slot_t;

	localparam rom_slot_t slot_fs       = 3'd0;
	localparam rom_slot_t slot_os       = 3'd1;
	localparam rom_slot_t slot_basic    = 3'd2;
	localparam rom_slot_t slot_pres     = 3'd3;
	localparam rom_slot_t slot_spare_a  = 3'd4;
	localparam rom_slot_t slot_spare_b  = 3'd5;
	localparam rom_slot_t slot_teletext = 3'd6;

	// Mouse step clamp and accumulated axis range
	localparam int mouse_step_max = 10;
	localparam int axis_min = -128;
	localparam int axis_max = 127;

endpackage

// File: elk_mem_map.sv
// External address decoder for the ROM slot table and the sideways RAM banks
`timescale 1ns/1ps

module elk_mem_map (
	input  elk_pkg::ext_addr_u                addr,
	output logic [elk_pkg::rom_addr_w-1:0]    rom_addr,
	output logic [elk_pkg::rom_addr_w-1:0]    ram_addr,
	output logic                              rom_hit,
	output logic                              ram_hit
);

	elk_pkg::rom_slot_t slot;

	////////////////////////////////////////////////////////////////////////////
	// ROM side, decoded by quad and bank
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		slot    = elk_pkg::slot_fs;
		rom_hit = 1'b0;
		if (!addr.rom_v.ram_flag) begin
			rom_hit = 1'b1;
			case ({addr.rom_v.quad, addr.rom_v.bank})
				// Filing system ROM, single page
				4'b01_00: slot = elk_pkg::slot_fs;
				// OS occupies two pages, both aliases of one image
				4'b10_00, 4'b10_01: slot = elk_pkg::slot_os;
				// BASIC likewise aliased over two pages
				4'b10_10, 4'b10_11: slot = elk_pkg::slot_basic;
				4'b11_00: slot = elk_pkg::slot_pres;
				4'b11_01: slot = elk_pkg::slot_spare_a;
				4'b11_10: slot = elk_pkg::slot_spare_b;
				4'b11_11: slot = elk_pkg::slot_teletext;
				// Quad 00 and the rest of quad 01 are empty
				default: rom_hit = 1'b0;
			endcase
		end
	end

	// Slot times page size plus offset
	assign rom_addr = {slot, addr.rom_v.offset};

	////////////////////////////////////////////////////////////////////////////
	// RAM side, decoded by bank number
	////////////////////////////////////////////////////////////////////////////

	// Banks 0 to 7 only, upper half of the RAM region unmapped
	assign ram_hit  = addr.ram_v.ram_flag && !addr.ram_v.bank_num[3];
	assign ram_addr = {addr.ram_v.bank_num[2:0], addr.ram_v.offset};

endmodule

// File: elk_spram.sv
// Byte-wide single-port RAM with write-first registered read
`timescale 1ns/1ps

module elk_spram #(
	parameter int words  = 1024,
	parameter int addr_w = 10
) (
	input  logic                clk_sys,
	input  logic [addr_w-1:0]   addr,
	input  elk_pkg::data_t      wdata,
	input  logic                we,
	output elk_pkg::data_t      rdata
);

	// Storage array
	elk_pkg::data_t mem [0:words-1];

	// New data appears on the read port in the write cycle
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
			rdata     <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

// File: elk_ext_bus.sv
// Four-phase core bus responder with ROM loader path, ROM and sideways RAM
`timescale 1ns/1ps

module elk_ext_bus (
	input  logic                              clk_sys,
	input  logic                              rst,
	// Core memory bus
	input  logic                              bus_req,
	input  logic                              bus_we,
	input  elk_pkg::ext_addr_u                bus_addr,
	input  elk_pkg::data_t                    bus_wdata,
	output logic                              bus_ack,
	output elk_pkg::data_t                    bus_rdata,
	// ROM download port
	input  logic                              load_active,
	input  logic                              load_wr,
	input  elk_pkg::data_t                    load_index,
	input  logic [elk_pkg::rom_addr_w-1:0]    load_addr,
	input  elk_pkg::data_t                    load_data
);

	logic [elk_pkg::rom_addr_w-1:0] map_rom_addr;
	logic [elk_pkg::rom_addr_w-1:0] map_ram_addr;
	logic [elk_pkg::rom_addr_w-1:0] rom_port_addr;
	logic                           map_rom_hit;
	logic                           map_ram_hit;
	logic                           rom_hit_q;
	logic                           ram_hit_q;
	logic                           accept;
	logic                           load_we;
	logic                           ram_we;
	elk_pkg::data_t                 rom_rdata;
	elk_pkg::data_t                 ram_rdata;

	elk_mem_map u_map (
		.addr     (bus_addr),
		.rom_addr (map_rom_addr),
		.ram_addr (map_ram_addr),
		.rom_hit  (map_rom_hit),
		.ram_hit  (map_ram_hit)
	);

	////////////////////////////////////////////////////////////////////////////
	// Handshake phase
	////////////////////////////////////////////////////////////////////////////

	// New request seen while idle, held off during a download
	assign accept = bus_req && !bus_ack && !load_active;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			bus_ack <= 1'b0;
		end else if (accept) begin
			bus_ack <= 1'b1;
		end else if (!bus_req) begin
			// Drop one cycle after req goes away
			bus_ack <= 1'b0;
		end
	end

	// Hit flags captured with the address of this transaction
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			rom_hit_q <= map_rom_hit;
			ram_hit_q <= map_ram_hit;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memories
	////////////////////////////////////////////////////////////////////////////

	// Loader owns the ROM port while active
	assign load_we       = load_active && load_wr && (load_index == '0);
	assign rom_port_addr = load_active ? load_addr : map_rom_addr;
	// One RAM write per transaction, ROM space never written from the bus
	assign ram_we        = accept && bus_we && map_ram_hit;

	elk_spram #(
		.words  (elk_pkg::rom_words),
		.addr_w (elk_pkg::rom_addr_w)
	) rom (
		.clk_sys (clk_sys),
		.addr    (rom_port_addr),
		.wdata   (load_data),
		.we      (load_we),
		.rdata   (rom_rdata)
	);

	elk_spram #(
		.words  (elk_pkg::ram_words),
		.addr_w (elk_pkg::rom_addr_w)
	) ram (
		.clk_sys (clk_sys),
		.addr    (map_ram_addr),
		.wdata   (bus_wdata),
		.we      (ram_we),
		.rdata   (ram_rdata)
	);

	// Unmapped pages read as zero
	always_comb begin
		if (!bus_ack) begin
			bus_rdata = '0;
		end else if (ram_hit_q) begin
			bus_rdata = ram_rdata;
		end else if (rom_hit_q) begin
			bus_rdata = rom_rdata;
		end else begin
			bus_rdata = '0;
		end
	end

	// Ack only ever answers a pending request
	a_ack_needs_req: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(bus_ack) |-> $past(bus_req));

	// Download must not steal the ROM port mid transaction
	a_no_load_in_ack: assert property (@(posedge clk_sys) disable iff (rst)
		load_we |-> !bus_ack);

endmodule

// File: elk_sd_route.sv
// Virtual or physical SD card routing, SPI activity timer and disk lights
`timescale 1ns/1ps

module elk_sd_route #(
	parameter int act_cycles = 2000000
) (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic        img_mounted,
	input  logic [63:0] img_size,
	input  logic        load_active,
	// SPI from the core
	input  logic        core_sck,
	input  logic        core_mosi,
	input  logic        core_ss,
	output logic        core_miso,
	// Virtual card
	input  logic        vsd_miso,
	output logic        vsd_ss,
	// Physical card pins
	input  logic        sd_miso,
	output logic        sd_sck,
	output logic        sd_mosi,
	output logic        sd_cs,
	output logic        led_disk,
	output logic        led_user
);

	localparam int cnt_w = $clog2(act_cycles + 1);

	logic             vsd_sel;
	logic             mosi_q;
	logic             miso_q;
	logic [cnt_w-1:0] act_cnt;
	logic             act;

	// Image with a size selects the virtual card, empty mount reverts
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vsd_sel <= 1'b0;
		end else if (img_mounted) begin
			vsd_sel <= |img_size;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pin gating
	////////////////////////////////////////////////////////////////////////////

	// Physical card parked deselected while virtual is in use
	assign sd_cs     = core_ss | vsd_sel;
	assign sd_sck    = core_sck & ~vsd_sel;
	assign sd_mosi   = core_mosi & ~vsd_sel;
	assign vsd_ss    = core_ss | ~vsd_sel;
	assign core_miso = vsd_sel ? vsd_miso : sd_miso;

	////////////////////////////////////////////////////////////////////////////
	// Activity timer
	////////////////////////////////////////////////////////////////////////////

	// Any edge on either data line restarts the count
	always_ff @(posedge clk_sys) begin
		mosi_q <= core_mosi;
		miso_q <= core_miso;
		if (rst) begin
			// Start saturated so the lights are off
			act_cnt <= cnt_w'(act_cycles);
		end else if ((mosi_q ^ core_mosi) || (miso_q ^ core_miso)) begin
			act_cnt <= '0;
		end else if (act_cnt < cnt_w'(act_cycles)) begin
			act_cnt <= act_cnt + 1'b1;
		end
	end

	assign act = act_cnt < cnt_w'(act_cycles);

	// Disk light for the real card, user light for download or virtual card
	assign led_disk = act & ~vsd_sel;
	assign led_user = load_active | (act & vsd_sel);

	// Physical bus fully quiet whenever the virtual card is selected
	a_phys_idle: assert property (@(posedge clk_sys) disable iff (rst)
		vsd_sel |-> (!sd_sck && !sd_mosi && sd_cs));

endmodule

// File: elk_mouse_axis.sv
// Mouse packet to analog stick emulation with clamp, saturation and pot output
`timescale 1ns/1ps

module elk_mouse_axis (
	input  logic        clk_sys,
	input  logic        rst,
	input  logic [24:0] mouse_pkt,
	input  logic [15:0] joy,
	input  logic [7:0]  joy_x,
	input  logic [7:0]  joy_y,
	input  logic        axis_off,
	output logic [7:0]  pot_x,
	output logic [7:0]  pot_y,
	output logic        fire
);

	logic [24:0]       pkt_q;
	logic              stb_q;
	logic              pkt_new;
	logic              emu;
	logic signed [8:0] acc_x;
	logic signed [8:0] acc_y;
	logic signed [8:0] dx_raw;
	logic signed [8:0] dy_raw;
	logic signed [8:0] nx;
	logic signed [8:0] ny;
	logic [7:0]        src_x;
	logic [7:0]        src_y;

	// Limit one packet step to the configured maximum
	function automatic logic signed [8:0] clamp_step(input logic signed [8:0] d);
		if (d > elk_pkg::mouse_step_max) begin
			return 9'(elk_pkg::mouse_step_max);
		end else if (d < -elk_pkg::mouse_step_max) begin
			return 9'(-elk_pkg::mouse_step_max);
		end
		return d;
	endfunction

	// Pin the accumulated position to the stick range
	function automatic logic signed [8:0] sat_axis(input logic signed [8:0] v);
		if (v > elk_pkg::axis_max) begin
			return 9'(elk_pkg::axis_max);
		end else if (v < elk_pkg::axis_min) begin
			return 9'(elk_pkg::axis_min);
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Packet strobe and accumulation
	////////////////////////////////////////////////////////////////////////////

	// Bit 24 toggles once per packet
	assign pkt_new = pkt_q[24] ^ stb_q;

	// Sign bit doubled over the top magnitude bits
	assign dx_raw = {pkt_q[4], pkt_q[4], pkt_q[15:9]};
	assign dy_raw = {pkt_q[5], pkt_q[5], pkt_q[23:17]};
	// Screen y grows downward
	assign nx = acc_x + clamp_step(dx_raw);
	assign ny = acc_y - clamp_step(dy_raw);

	always_ff @(posedge clk_sys) begin
		pkt_q <= mouse_pkt;
		stb_q <= pkt_q[24];
		if (rst) begin
			emu   <= 1'b0;
			acc_x <= '0;
			acc_y <= '0;
		end else if ((|joy) || axis_off) begin
			// Stick use hands control back to the joystick
			emu   <= 1'b0;
			acc_x <= '0;
			acc_y <= '0;
		end else if (pkt_new) begin
			emu   <= 1'b1;
			acc_x <= sat_axis(nx);
			acc_y <= sat_axis(ny);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Source select and pot conversion
	////////////////////////////////////////////////////////////////////////////

	assign src_x = emu ? acc_x[7:0] : joy_x;
	assign src_y = emu ? acc_y[7:0] : joy_y;
	// Either mouse button counts as fire
	assign fire  = emu ? (|pkt_q[1:0]) : joy[4];

	// Offset binary, then inverted for the pot
	assign pot_x = 8'hff - {~src_x[7], src_x[6:0]};
	assign pot_y = 8'hff - {~src_y[7], src_y[6:0]};

	a_axis_range: assert property (@(posedge clk_sys) disable iff (rst)
		(acc_x >= elk_pkg::axis_min) && (acc_x <= elk_pkg::axis_max) &&
		(acc_y >= elk_pkg::axis_min) && (acc_y <= elk_pkg::axis_max));

endmodule

// File: elk_top.sv
// Wrapper top level with memory bus, SD routing and mouse axis emulation
`timescale 1ns/1ps

module elk_top #(
	parameter int act_cycles = 2000000
) (
	input  logic                              clk_sys,
	input  logic                              rst,
	// Core memory bus
	input  logic                              bus_req,
	input  logic                              bus_we,
	input  elk_pkg::ext_addr_u                bus_addr,
	input  elk_pkg::data_t                    bus_wdata,
	output logic                              bus_ack,
	output elk_pkg::data_t                    bus_rdata,
	// ROM download
	input  logic                              load_active,
	input  logic                              load_wr,
	input  elk_pkg::data_t                    load_index,
	input  logic [elk_pkg::rom_addr_w-1:0]    load_addr,
	input  elk_pkg::data_t                    load_data,
	// SD card
	input  logic                              img_mounted,
	input  logic [63:0]                       img_size,
	input  logic                              core_sck,
	input  logic                              core_mosi,
	input  logic                              core_ss,
	output logic                              core_miso,
	input  logic                              vsd_miso,
	output logic                              vsd_ss,
	input  logic                              sd_miso,
	output logic                              sd_sck,
	output logic                              sd_mosi,
	output logic                              sd_cs,
	output logic                              led_disk,
	output logic                              led_user,
	// Mouse and stick
	input  logic [24:0]                       mouse_pkt,
	input  logic [15:0]                       joy,
	input  logic [7:0]                        joy_x,
	input  logic [7:0]                        joy_y,
	input  logic                              axis_off,
	output logic [7:0]                        pot_x,
	output logic [7:0]                        pot_y,
	output logic                              fire
);

	elk_ext_bus u_bus (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.bus_req     (bus_req),
		.bus_we      (bus_we),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.bus_ack     (bus_ack),
		.bus_rdata   (bus_rdata),
		.load_active (load_active),
		.load_wr     (load_wr),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_data   (load_data)
	);

	elk_sd_route #(
		.act_cycles (act_cycles)
	) u_sd (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.load_active (load_active),
		.core_sck    (core_sck),
		.core_mosi   (core_mosi),
		.core_ss     (core_ss),
		.core_miso   (core_miso),
		.vsd_miso    (vsd_miso),
		.vsd_ss      (vsd_ss),
		.sd_miso     (sd_miso),
		.sd_sck      (sd_sck),
		.sd_mosi     (sd_mosi),
		.sd_cs       (sd_cs),
		.led_disk    (led_disk),
		.led_user    (led_user)
	);

	elk_mouse_axis u_mouse (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.mouse_pkt (mouse_pkt),
		.joy       (joy),
		.joy_x     (joy_x),
		.joy_y     (joy_y),
		.axis_off  (axis_off),
		.pot_x     (pot_x),
		.pot_y     (pot_y),
		.fire      (fire)
	);

endmodule

// File: tb_clk_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_sys,
	output logic rst
);

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Reset held over the first five rising edges
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk_sys);
		#1 rst = 1'b0;
	end

endmodule

// File: tb_elk.sv
// Directed tests of bus, ROM load, SD routing, activity lights and mouse axis
`timescale 1ns/1ps

module tb_elk;

	localparam int act_cycles = 64;
	localparam int wait_limit = 50;

	logic               clk_sys;
	logic               rst;
	logic               bus_req;
	logic               bus_we;
	elk_pkg::ext_addr_u bus_addr;
	elk_pkg::data_t     bus_wdata;
	logic               bus_ack;
	elk_pkg::data_t     bus_rdata;
	logic               load_active;
	logic               load_wr;
	elk_pkg::data_t     load_index;
	logic [16:0]        load_addr;
	elk_pkg::data_t     load_data;
	logic               img_mounted;
	logic [63:0]        img_size;
	logic               core_sck, core_mosi, core_ss, core_miso;
	logic               vsd_miso, vsd_ss;
	logic               sd_miso, sd_sck, sd_mosi, sd_cs;
	logic               led_disk, led_user;
	logic [24:0]        mouse_pkt;
	logic [15:0]        joy;
	logic [7:0]         joy_x, joy_y;
	logic               axis_off;
	logic [7:0]         pot_x, pot_y;
	logic               fire;

	// Bookkeeping
	int          errors;
	int          checks;
	int          tests;
	string       cur_test;
	logic [31:0] lfsr_state;
	// Expected ROM bytes per slot and offset, and RAM bytes per bank
	elk_pkg::data_t rom_exp [7][3];
	elk_pkg::data_t ram_vals [8];
	logic [13:0]    rom_offs [3] = '{14'h0000, 14'h1234, 14'h3fff};
	// Mouse reference position
	int mx;
	int my;

	tb_clk_gen u_clk (
		.clk_sys (clk_sys),
		.rst     (rst)
	);

	elk_top #(
		.act_cycles (act_cycles)
	) dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Drive point, 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic rand_byte(output elk_pkg::data_t b);
		for (int i = 0; i < 8; i++) begin
			b[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_data(input string label, input elk_pkg::data_t exp,
			input elk_pkg::data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s %s: expected %02h, actual %02h", cur_test, label, exp, act);
		end
	endtask

	task automatic check_bit(input string label, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s %s: expected %0b, actual %0b", cur_test, label, exp, act);
		end
	endtask

	task automatic check_pot(input string label, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s %s: expected %0d, actual %0d", cur_test, label, exp, act);
		end
	endtask

	task automatic finish_test(input int e0);
		tests++;
		if (errors == e0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, errors - e0);
		end
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (bus_ack !== level && n < wait_limit) begin
			tick();
			n++;
		end
		if (bus_ack !== level) begin
			errors++;
			$display("%s: timed out waiting for bus_ack to go %0b", cur_test, level);
		end
	endtask

	// Full four-phase transaction
	task automatic bus_access(input elk_pkg::ext_addr_u addr, input logic we,
			input elk_pkg::data_t wdata, output elk_pkg::data_t rdata);
		bus_addr  = addr;
		bus_we    = we;
		bus_wdata = wdata;
		bus_req   = 1'b1;
		wait_ack(1'b1);
		rdata   = bus_rdata;
		bus_req = 1'b0;
		bus_we  = 1'b0;
		wait_ack(1'b0);
	endtask

	function automatic elk_pkg::ext_addr_u make_addr(input logic ram, input logic [3:0] page,
			input logic [13:0] off);
		return {ram, page, off};
	endfunction

	// Slot behind a ROM page, -1 for an empty page
	function automatic int rom_page_slot(input logic [3:0] page);
		if (page == 4'b0100) begin
			return 0;
		end else if (page[3:2] == 2'b10) begin
			return 1 + int'(page[1]);
		end else if (page[3:2] == 2'b11) begin
			return 3 + int'(page[1:0]);
		end
		return -1;
	endfunction

	// 255 minus offset binary
	function automatic logic [7:0] pot_of(input int v);
		return 8'(127 - v);
	endfunction

	function automatic int axis_step(input int acc, input int d);
		int s;
		s = d;
		if (s > elk_pkg::mouse_step_max) s = elk_pkg::mouse_step_max;
		if (s < -elk_pkg::mouse_step_max) s = -elk_pkg::mouse_step_max;
		s = acc + s;
		if (s > elk_pkg::axis_max) s = elk_pkg::axis_max;
		if (s < elk_pkg::axis_min) s = elk_pkg::axis_min;
		return s;
	endfunction

	function automatic logic [24:0] mouse_packet(input logic strobe, input int dx,
			input int dy, input logic [1:0] btn);
		logic [8:0]  x9;
		logic [8:0]  y9;
		logic [24:0] p;
		x9       = 9'(dx);
		y9       = 9'(dy);
		p        = '0;
		p[24]    = strobe;
		p[23:17] = y9[6:0];
		p[15:9]  = x9[6:0];
		p[5]     = y9[8];
		p[4]     = x9[8];
		p[1:0]   = btn;
		return p;
	endfunction

	task automatic mount(input logic [63:0] size);
		img_size    = size;
		img_mounted = 1'b1;
		tick();
		img_mounted = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_rom_load();
		int             e0;
		int             s;
		elk_pkg::data_t d;
		cur_test    = "rom_load";
		e0          = errors;
		load_active = 1'b1;
		for (int slot = 0; slot < 7; slot++) begin
			for (int k = 0; k < 3; k++) begin
				rand_byte(d);
				rom_exp[slot][k] = d;
				load_addr = {3'(slot), rom_offs[k]};
				load_data = d;
				load_wr   = 1'b1;
				tick();
			end
		end
		load_wr = 1'b0;
		check_bit("led_user while loading", 1'b1, led_user);
		// Request parked until the download ends
		bus_addr = make_addr(1'b0, 4'b1000, rom_offs[1]);
		bus_we   = 1'b0;
		bus_req  = 1'b1;
		repeat (4) begin
			tick();
			check_bit("ack held off during load", 1'b0, bus_ack);
		end
		load_active = 1'b0;
		wait_ack(1'b1);
		check_data("read after load", rom_exp[1][1], bus_rdata);
		bus_req = 1'b0;
		wait_ack(1'b0);
		// Every ROM page, aliases and empty pages included
		for (int p = 0; p < 16; p++) begin
			s = rom_page_slot(4'(p));
			for (int k = 0; k < 3; k++) begin
				bus_access(make_addr(1'b0, 4'(p), rom_offs[k]), 1'b0, 8'h00, d);
				if (s < 0) begin
					check_data("empty rom page", 8'h00, d);
				end else begin
					check_data("rom page", rom_exp[s][k], d);
				end
			end
		end
		finish_test(e0);
	endtask

	task automatic test_ram_banks();
		int             e0;
		elk_pkg::data_t d;
		cur_test = "ram_banks";
		e0       = errors;
		// Bank number in the low bits keeps the bytes distinct
		for (int b = 0; b < 8; b++) begin
			rand_byte(d);
			ram_vals[b] = {d[4:0], 3'(b)};
			bus_access(make_addr(1'b1, 4'(b), 14'h0a5a), 1'b1, ram_vals[b], d);
		end
		for (int b = 0; b < 8; b++) begin
			bus_access(make_addr(1'b1, 4'(b), 14'h0a5a), 1'b0, 8'h00, d);
			check_data("bank read", ram_vals[b], d);
		end
		// Upper banks are empty
		bus_access(make_addr(1'b1, 4'd9, 14'h0a5a), 1'b1, 8'h5a, d);
		for (int b = 8; b < 16; b++) begin
			bus_access(make_addr(1'b1, 4'(b), 14'h0a5a), 1'b0, 8'h00, d);
			check_data("empty ram page", 8'h00, d);
		end
		bus_access(make_addr(1'b1, 4'd1, 14'h0a5a), 1'b0, 8'h00, d);
		check_data("bank 1 after empty write", ram_vals[1], d);
		// BASIC page is read only
		bus_access(make_addr(1'b0, 4'b1010, rom_offs[1]), 1'b1, ~rom_exp[2][1], d);
		bus_access(make_addr(1'b0, 4'b1010, rom_offs[1]), 1'b0, 8'h00, d);
		check_data("rom after bus write", rom_exp[2][1], d);
		finish_test(e0);
	endtask

	task automatic test_handshake();
		int e0;
		cur_test = "handshake";
		e0       = errors;
		bus_addr = make_addr(1'b1, 4'd3, 14'h0a5a);
		bus_we   = 1'b0;
		check_bit("ack idle", 1'b0, bus_ack);
		bus_req = 1'b1;
		tick();
		check_bit("ack one cycle after req", 1'b1, bus_ack);
		check_data("rdata with ack", ram_vals[3], bus_rdata);
		repeat (3) begin
			tick();
			check_bit("ack held with req", 1'b1, bus_ack);
		end
		bus_req = 1'b0;
		tick();
		check_bit("ack cleared after req", 1'b0, bus_ack);
		finish_test(e0);
	endtask

	// All pin combinations against the routing rule
	task automatic route_sweep(input logic sel);
		for (int i = 0; i < 32; i++) begin
			{sd_miso, vsd_miso, core_ss, core_mosi, core_sck} = 5'(i);
			#1;
			if (sel) begin
				check_bit("sd_cs", 1'b1, sd_cs);
				check_bit("sd_sck", 1'b0, sd_sck);
				check_bit("sd_mosi", 1'b0, sd_mosi);
				check_bit("vsd_ss", core_ss, vsd_ss);
				check_bit("core_miso", vsd_miso, core_miso);
			end else begin
				check_bit("sd_cs", core_ss, sd_cs);
				check_bit("sd_sck", core_sck, sd_sck);
				check_bit("sd_mosi", core_mosi, sd_mosi);
				check_bit("vsd_ss", 1'b1, vsd_ss);
				check_bit("core_miso", sd_miso, core_miso);
			end
			tick();
		end
	endtask

	task automatic test_sd_routing();
		int e0;
		cur_test = "sd_routing";
		e0       = errors;
		mount(64'h0001_0000);
		route_sweep(1'b1);
		mount(64'd0);
		route_sweep(1'b0);
		finish_test(e0);
	endtask

	task automatic light_run(input logic sel);
		int n;
		mount(sel ? 64'd2048 : 64'd0);
		repeat (70) tick();
		check_bit("led_disk idle", 1'b0, led_disk);
		check_bit("led_user idle", 1'b0, led_user);
		core_mosi = ~core_mosi;
		n = 0;
		do begin
			tick();
			n++;
		end while (!(sel ? led_user : led_disk) && n < 2);
		check_bit("light within 2 cycles", 1'b1, sel ? led_user : led_disk);
		check_bit("other light", 1'b0, sel ? led_disk : led_user);
		repeat (32 - n) tick();
		check_bit("light after 32 quiet", 1'b1, sel ? led_user : led_disk);
		repeat (38) tick();
		check_bit("light after 70 quiet", 1'b0, sel ? led_user : led_disk);
	endtask

	task automatic test_lights();
		int e0;
		cur_test = "activity_lights";
		e0       = errors;
		light_run(1'b0);
		light_run(1'b1);
		finish_test(e0);
	endtask

	task automatic send_packet(input int dx, input int dy, input logic [1:0] btn);
		mouse_pkt = mouse_packet(~mouse_pkt[24], dx, dy, btn);
		mx = axis_step(mx, dx);
		my = axis_step(my, -dy);
		// Takes effect on the second edge after the toggle
		repeat (2) tick();
		check_pot("pot_x", pot_of(mx), pot_x);
		check_pot("pot_y", pot_of(my), pot_y);
		check_bit("fire", |btn, fire);
	endtask

	task automatic test_mouse_axis();
		int e0;
		cur_test = "mouse_axis";
		e0       = errors;
		mx       = 0;
		my       = 0;
		// Stick value away from the zero accumulator
		joy_x = 8'h20;
		tick();
		check_pot("stick pot_x before mouse", pot_of(32), pot_x);
		send_packet(4, 0, 2'b00);
		send_packet(30, 100, 2'b01);
		send_packet(-30, -90, 2'b10);
		// Drive both axes into saturation
		for (int i = 0; i < 14; i++) begin
			send_packet(30, 120, 2'(i));
		end
		// Buttons released so stick fire comes from joy bit 4 alone
		send_packet(0, -127, 2'b00);
		// Stick takes over
		joy_x = 8'h40;
		joy_y = 8'hc0;
		joy   = 16'h0010;
		tick();
		check_pot("stick pot_x", pot_of(64), pot_x);
		check_pot("stick pot_y", pot_of(-64), pot_y);
		check_bit("stick fire", 1'b1, fire);
		// Accumulators restart from zero
		joy = 16'h0000;
		mx  = 0;
		my  = 0;
		send_packet(4, -3, 2'b00);
		finish_test(e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int n;
		lfsr_state  = 32'hbc9d;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		bus_req     = 1'b0;
		bus_we      = 1'b0;
		bus_addr    = '0;
		bus_wdata   = '0;
		load_active = 1'b0;
		load_wr     = 1'b0;
		load_index  = '0;
		load_addr   = '0;
		load_data   = '0;
		img_mounted = 1'b0;
		img_size    = '0;
		core_sck    = 1'b0;
		core_mosi   = 1'b0;
		core_ss     = 1'b1;
		vsd_miso    = 1'b0;
		sd_miso     = 1'b0;
		mouse_pkt   = '0;
		joy         = '0;
		joy_x       = '0;
		joy_y       = '0;
		axis_off    = 1'b0;
		cur_test    = "reset";
		n = 0;
		while (rst !== 1'b0 && n < 20) begin
			tick();
			n++;
		end
		if (rst !== 1'b0) begin
			errors++;
			$display("Reset was never released");
		end
		test_rom_load();
		test_ram_banks();
		test_handshake();
		test_sd_routing();
		test_lights();
		test_mouse_axis();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
elk_pkg.sv
elk_mem_map.sv
elk_spram.sv
elk_ext_bus.sv
elk_sd_route.sv
elk_mouse_axis.sv
elk_top.sv
tb_clk_gen.sv
tb_elk.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_elk -o tb_elk_sim \
	&& out="$(./obj_dir/tb_elk_sim)" \
	&& printf '%s\n' "$out" \
	&& printf '%s\n' "$out" | grep -q "TEST PASS" \
	|| exit 1
